// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_ahb_wb_bridge \
		--Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/ahb_addr_capture.sv ====
`timescale 1ns/1ps

module ahb_addr_capture (
    input  logic                clk_core,
    input  logic                rst_core,
    input  ahb_wb_pkg::addr_t   haddr_i,
    input  ahb_wb_pkg::htrans_t htrans_i,
    input  logic                hwrite_i,
    input  ahb_wb_pkg::hsize_t  hsize_i,
    input  logic                hready_i,   // Own HREADYOUT fed back
    bus_req_if.capture          req
);
    import ahb_wb_pkg::*;

    logic  active;
    logic  accept;
    sel_t  sel_d;
    logic  misaligned_d;

    logic  valid_q;
    addr_t addr_q;
    logic  write_q;
    sel_t  sel_q;
    logic  misaligned_q;

    // NONSEQ and SEQ carry a transfer, each beat handled alone
    always_comb begin
        case (htrans_i)
            htrans_nonseq, htrans_seq: active = 1'b1;
            default:                   active = 1'b0;
        endcase
    end

    assign accept = hready_i && active;

    // Byte lanes from size and low address bits
    always_comb begin
        sel_d        = '0;
        misaligned_d = 1'b0;
        case (hsize_i)
            3'd0: begin
                sel_d = sel_t'(1) << haddr_i[1:0];
            end
            3'd1: begin
                sel_d        = sel_t'(3) << {haddr_i[1], 1'b0};
                misaligned_d = haddr_i[0];
            end
            3'd2: begin
                sel_d        = '1;
                misaligned_d = |haddr_i[1:0];
            end
            default: begin
                misaligned_d = 1'b1;    // Wider than the bus
            end
        endcase
    end

    // Valid held until the sequencer takes the request
    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            valid_q <= 1'b0;
        end else begin
            if (req.valid && req.ready)
                valid_q <= 1'b0;
            if (accept)
                valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (accept) begin
            addr_q       <= haddr_i;
            write_q      <= hwrite_i;
            sel_q        <= sel_d;
            misaligned_q <= misaligned_d;
        end
    end

    assign req.valid      = valid_q;
    assign req.addr       = addr_q;
    assign req.write      = write_q;
    assign req.sel        = sel_q;
    assign req.misaligned = misaligned_q;

endmodule

// ==== design/ahb_resp_gen.sv ====
`timescale 1ns/1ps

module ahb_resp_gen (
    input  logic                clk_core,
    input  logic                rst_core,
    bus_resp_if.resp            resp,
    input  ahb_wb_pkg::htrans_t htrans_i,
    output logic                hready_o,
    output ahb_wb_pkg::data_t   hrdata_o,
    output logic                hresp_o
);
    import ahb_wb_pkg::*;

    logic active;
    logic err_pend_q;   // First ERROR cycle done, second still to come

    // IDLE and BUSY get a zero-wait OKAY
    assign active = !(htrans_i == htrans_idle || htrans_i == htrans_busy);

    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            hready_o   <= 1'b1;
            hresp_o    <= 1'b0;
            err_pend_q <= 1'b0;
        end else if (resp.valid) begin
            if (resp.err) begin
                // ERROR, first cycle with HREADYOUT still low
                hresp_o    <= 1'b1;
                err_pend_q <= 1'b1;
            end else begin
                hready_o <= 1'b1;
                hresp_o  <= 1'b0;
            end
        end else if (err_pend_q) begin
            hready_o   <= 1'b1;   // Second ERROR cycle
            err_pend_q <= 1'b0;
        end else if (hready_o) begin
            hresp_o <= 1'b0;
            if (active)
                hready_o <= 1'b0;   // New address phase taken, stall its data phase
        end
    end

    // Read data for an OKAY response
    always_ff @(posedge clk_core) begin
        if (resp.valid && !resp.err)
            hrdata_o <= resp.rdata;
    end

endmodule

// ==== design/ahb_wb_bridge_top.sv ====
`timescale 1ns/1ps

module ahb_wb_bridge_top (
    input  logic                clk_core,
    input  logic                rst_core,

    // AHB-Lite slave
    input  ahb_wb_pkg::addr_t   haddr_i,
    input  ahb_wb_pkg::htrans_t htrans_i,
    input  logic                hwrite_i,
    input  ahb_wb_pkg::hsize_t  hsize_i,
    input  ahb_wb_pkg::data_t   hwdata_i,
    output logic                hready_o,
    output ahb_wb_pkg::data_t   hrdata_o,
    output logic                hresp_o,

    // Wishbone master, classic cycles
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output ahb_wb_pkg::sel_t    wb_sel_o,
    output ahb_wb_pkg::addr_t   wb_adr_o,
    output ahb_wb_pkg::data_t   wb_dat_o,
    input  ahb_wb_pkg::data_t   wb_dat_i,
    input  logic                wb_ack_i
);

    bus_req_if  req_if ();
    bus_resp_if resp_if ();

    ahb_addr_capture u_capture (
        .clk_core (clk_core),
        .rst_core (rst_core),
        .haddr_i  (haddr_i),
        .htrans_i (htrans_i),
        .hwrite_i (hwrite_i),
        .hsize_i  (hsize_i),
        .hready_i (hready_o),   // Own HREADYOUT, single slave
        .req      (req_if.capture)
    );

    wb_cycle_seq u_seq (
        .clk_core (clk_core),
        .rst_core (rst_core),
        .hwdata_i (hwdata_i),
        .req      (req_if.seq),
        .resp     (resp_if.seq),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_sel_o (wb_sel_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    ahb_resp_gen u_resp (
        .clk_core (clk_core),
        .rst_core (rst_core),
        .resp     (resp_if.resp),
        .htrans_i (htrans_i),
        .hready_o (hready_o),
        .hrdata_o (hrdata_o),
        .hresp_o  (hresp_o)
    );

endmodule

// ==== design/ahb_wb_pkg.sv ====
package ahb_wb_pkg;

    // Bus widths, fixed for this bridge
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int sel_w  = data_w / 8;   // One select bit per byte lane

    // Byte address, same on both buses
    typedef logic [addr_w-1:0] addr_t;

    // One bus word
    typedef logic [data_w-1:0] data_t;

    // Wishbone byte-lane select
    typedef logic [sel_w-1:0] sel_t;

    // AHB transfer type and size
    typedef logic [1:0] htrans_t;
    typedef logic [2:0] hsize_t;

    // HTRANS encodings
    localparam htrans_t htrans_idle   = 2'd0;
    localparam htrans_t htrans_busy   = 2'd1;
    localparam htrans_t htrans_nonseq = 2'd2;
    localparam htrans_t htrans_seq    = 2'd3;

    // Wishbone cycle sequencer
    typedef enum logic [1:0] {
        seq_idle,   // Waiting for a captured request
        seq_bus,    // Wishbone cycle running
        seq_skip    // Misaligned, error response without a bus cycle
    } seq_state_t;

endpackage

// ==== design/bus_req_if.sv ====
`timescale 1ns/1ps

// One captured AHB address phase, capture stage to sequencer
interface bus_req_if;
    import ahb_wb_pkg::*;

    logic  valid;
    logic  ready;
    addr_t addr;        // Full byte address
    logic  write;
    sel_t  sel;         // Lane select from size and offset
    logic  misaligned;  // Address not aligned to size, or size above a word

    modport capture (
        output valid,
        input  ready,
        output addr,
        output write,
        output sel,
        output misaligned
    );

    modport seq (
        input  valid,
        output ready,
        input  addr,
        input  write,
        input  sel,
        input  misaligned
    );

endinterface

// ==== design/bus_resp_if.sv ====
`timescale 1ns/1ps

// Result of a finished transfer, sequencer to response generator
// No ready here, the generator takes every response on arrival
interface bus_resp_if;
    import ahb_wb_pkg::*;

    logic  valid;   // Single-cycle pulse
    data_t rdata;
    logic  err;

    modport seq (
        output valid,
        output rdata,
        output err
    );

    modport resp (
        input  valid,
        input  rdata,
        input  err
    );

endinterface

// ==== design/wb_cycle_seq.sv ====
`timescale 1ns/1ps

module wb_cycle_seq (
    input  logic              clk_core,
    input  logic              rst_core,
    input  ahb_wb_pkg::data_t hwdata_i,   // Held stable by the master while stalled
    bus_req_if.seq            req,
    bus_resp_if.seq           resp,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output ahb_wb_pkg::sel_t  wb_sel_o,
    output ahb_wb_pkg::addr_t wb_adr_o,
    output ahb_wb_pkg::data_t wb_dat_o,
    input  ahb_wb_pkg::data_t wb_dat_i,
    input  logic              wb_ack_i
);
    import ahb_wb_pkg::*;

    seq_state_t state_q;
    logic       handshake;
    logic       bus_done;

    logic       resp_valid_q;
    logic       resp_err_q;
    logic       we_q;
    data_t      rdata_q;
    addr_t      adr_q;
    sel_t       sel_q;
    data_t      wdata_q;

    // One request at a time, taken only when idle
    assign req.ready = (state_q == seq_idle);
    assign handshake = req.valid && req.ready;
    assign bus_done  = (state_q == seq_bus) && wb_ack_i;

    always_ff @(posedge clk_core) begin
        if (rst_core) begin
            state_q      <= seq_idle;
            resp_valid_q <= 1'b0;
            resp_err_q   <= 1'b0;
            we_q         <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;   // Response is a pulse
            case (state_q)
                seq_idle: begin
                    if (handshake) begin
                        if (req.misaligned) begin
                            state_q <= seq_skip;
                        end else begin
                            state_q <= seq_bus;
                            we_q    <= req.write;
                        end
                    end
                end
                seq_bus: begin
                    if (wb_ack_i) begin
                        state_q      <= seq_idle;
                        resp_valid_q <= 1'b1;
                        resp_err_q   <= 1'b0;
                        we_q         <= 1'b0;
                    end
                end
                seq_skip: begin
                    // No bus activity, straight to an error response
                    state_q      <= seq_idle;
                    resp_valid_q <= 1'b1;
                    resp_err_q   <= 1'b1;
                end
                default: begin
                    state_q <= seq_idle;
                end
            endcase
        end
    end

    // Request payload, latched on acceptance
    always_ff @(posedge clk_core) begin
        if (handshake && !req.misaligned) begin
            adr_q   <= {req.addr[addr_w-1:2], 2'b00};   // Byte offset lives in sel
            sel_q   <= req.sel;
            wdata_q <= hwdata_i;
        end
        if (bus_done)
            rdata_q <= wb_dat_i;
    end

    // cyc and stb rise and fall together
    assign wb_cyc_o = (state_q == seq_bus);
    assign wb_stb_o = (state_q == seq_bus);
    assign wb_we_o  = we_q;
    assign wb_sel_o = sel_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = wdata_q;

    assign resp.valid = resp_valid_q;
    assign resp.rdata = rdata_q;
    assign resp.err   = resp_err_q;

endmodule

// ==== src.f ====
design/ahb_wb_pkg.sv
design/bus_req_if.sv
design/bus_resp_if.sv
design/ahb_addr_capture.sv
design/wb_cycle_seq.sv
design/ahb_resp_gen.sv
design/ahb_wb_bridge_top.sv
tb/ahb_wb_bridge_assertions.sv
tb/tb_ahb_wb_bridge.sv

// ==== tb/ahb_wb_bridge_assertions.sv ====
`timescale 1ns/1ps

module ahb_wb_bridge_assertions (
    input logic              clk_core,
    input logic              rst_core,
    input logic              wb_cyc_o,
    input logic              wb_stb_o,
    input logic              wb_we_o,
    input ahb_wb_pkg::sel_t  wb_sel_o,
    input ahb_wb_pkg::addr_t wb_adr_o,
    input ahb_wb_pkg::data_t wb_dat_o,
    input logic              wb_ack_i,
    input logic              hready_o,
    input logic              hresp_o
);

    int fail_cnt = 0;   // Failed assertion count

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk_core) disable iff (rst_core)
        wb_stb_o |-> wb_cyc_o)
        else begin
            $error("wb_stb_o high while wb_cyc_o is low");
            fail_cnt++;
        end

    // Request held until the slave acks
    wb_hold: assert property (@(posedge clk_core) disable iff (rst_core)
        (wb_stb_o && !wb_ack_i) |=>
            (wb_stb_o && $stable({wb_we_o, wb_sel_o, wb_adr_o, wb_dat_o})))
        else begin
            $error("Wishbone request changed or dropped before ack");
            fail_cnt++;
        end

    // ERROR takes two cycles, the second with HREADYOUT high
    err_second: assert property (@(posedge clk_core) disable iff (rst_core)
        (hresp_o && !hready_o) |=> (hresp_o && hready_o))
        else begin
            $error("first ERROR cycle not followed by the second");
            fail_cnt++;
        end

endmodule

bind ahb_wb_bridge_top ahb_wb_bridge_assertions u_assertions (
    .clk_core (clk_core),
    .rst_core (rst_core),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_sel_o (wb_sel_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_ack_i (wb_ack_i),
    .hready_o (hready_o),
    .hresp_o  (hresp_o)
);

// ==== tb/tb_ahb_wb_bridge.sv ====
`timescale 1ns/1ps

module tb_ahb_wb_bridge;
    import ahb_wb_pkg::*;

    localparam int rand_delay = -1;   // Drawn from $urandom when the table is built

    typedef struct {
        htrans_t trans;
        logic    write;
        addr_t   addr;
        hsize_t  size;
        data_t   wdata;
        int      delay;     // Wait cycles before ack
        logic    err;       // ERROR response expected
    } row_t;

    logic    clk_core;
    logic    rst_core;
    addr_t   haddr_i;
    htrans_t htrans_i;
    logic    hwrite_i;
    hsize_t  hsize_i;
    data_t   hwdata_i;
    logic    hready_o;
    data_t   hrdata_o;
    logic    hresp_o;
    logic    wb_cyc_o;
    logic    wb_stb_o;
    logic    wb_we_o;
    sel_t    wb_sel_o;
    addr_t   wb_adr_o;
    data_t   wb_dat_o;
    data_t   wb_dat_i = '0;
    logic    wb_ack_i = 1'b0;

    row_t  rows[$];
    data_t shadow [64];     // Expected memory contents
    data_t wb_mem [64];
    int    cur_delay = 1;
    int    wait_cnt = 0;
    int    cyc_starts = 0;
    logic  cyc_q = 1'b0;
    logic  seen_we;         // Captured at the acked beat
    sel_t  seen_sel;
    addr_t seen_adr;
    logic  prev_hready;
    logic  prev_hresp;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    int    checks = 0;
    int    errors = 0;
    int    row_errors = 0;

    ahb_wb_bridge_top DUT (
        .clk_core (clk_core),
        .rst_core (rst_core),
        .haddr_i  (haddr_i),
        .htrans_i (htrans_i),
        .hwrite_i (hwrite_i),
        .hsize_i  (hsize_i),
        .hwdata_i (hwdata_i),
        .hready_o (hready_o),
        .hrdata_o (hrdata_o),
        .hresp_o  (hresp_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_sel_o (wb_sel_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    function automatic data_t fill_word(addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    // Lanes covered by 2^size bytes from the aligned offset
    function automatic sel_t lane_mask(hsize_t s, addr_t a);
        int   nbytes;
        int   first;
        sel_t m;
        nbytes = (s > 3'd2) ? 4 : (1 << s);
        first  = int'(a[1:0]) & ~(nbytes - 1);
        m      = '0;
        for (int b = 0; b < 4; b++)
            m[b] = (b >= first) && (b < first + nbytes);
        return m;
    endfunction

    function automatic bit is_active(htrans_t t);
        return t == htrans_nonseq || t == htrans_seq;
    endfunction

    function automatic int expected_latency(row_t r);
        if (!is_active(r.trans))
            return 1;                   // Zero-wait OKAY
        if (r.err)
            return 5;                   // Skip state plus two ERROR cycles
        return r.delay + 4;
    endfunction

    function automatic string kind_name(row_t r);
        if (!is_active(r.trans))
            return "idle";
        if (r.err)
            return "error";
        return r.write ? "write" : "read";
    endfunction

    task automatic add_row(input htrans_t trans, input logic write, input addr_t addr,
                           input hsize_t size, input data_t wdata, input int delay,
                           input logic err);
        row_t r;
        r.trans = trans;
        r.write = write;
        r.addr  = addr;
        r.size  = size;
        r.wdata = wdata;
        r.delay = (delay == rand_delay) ? 1 + int'($urandom % 6) : delay;
        r.err   = err;
        rows.push_back(r);
        cycle_limit += r.delay + 8;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s expected %h, got %h", name, exp, got);
            errors++;
            row_errors++;
        end
    endtask

    task automatic drive_addr(input int i);
        htrans_i <= rows[i].trans;
        haddr_i  <= rows[i].addr;
        hwrite_i <= rows[i].write;
        hsize_i  <= rows[i].size;
    endtask

    task automatic finish_row(input int i, input int latency, input int starts);
        row_t  r;
        sel_t  mask;
        int    idx;
        r = rows[i];
        mask = lane_mask(r.size, r.addr);
        idx = int'(r.addr[7:2]);
        row_errors = 0;
        check_value("latency", expected_latency(r), latency);
        if (!is_active(r.trans)) begin
            check_value("hresp_o", 0, 32'(hresp_o));
            check_value("wb_cyc_o starts", 0, starts);
        end else if (r.err) begin
            check_value("hresp_o", 1, 32'(hresp_o));
            check_value("hresp_o first cycle", 1, 32'(prev_hresp));
            check_value("hready_o first cycle", 0, 32'(prev_hready));
            check_value("wb_cyc_o starts", 0, starts);   // No bus cycle for an error
        end else begin
            check_value("hresp_o", 0, 32'(hresp_o));
            check_value("wb_cyc_o starts", 1, starts);
            check_value("wb_we_o", 32'(r.write), 32'(seen_we));
            check_value("wb_sel_o", 32'(mask), 32'(seen_sel));
            check_value("wb_adr_o", r.addr & 32'hFFFF_FFFC, seen_adr);
            if (r.write) begin
                for (int b = 0; b < 4; b++)
                    if (mask[b])
                        shadow[idx][8*b +: 8] = r.wdata[8*b +: 8];
            end else begin
                check_value("hrdata_o", shadow[idx], hrdata_o);
            end
        end
        $display("row %0d %s addr %h size %0d: %s", i, kind_name(r), r.addr, r.size,
                 (row_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        clk_core = 1'b0;
        forever #20 clk_core = ~clk_core;
    end

    always @(posedge clk_core) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: transfers still running after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // Wishbone memory that acks after cur_delay cycles of stb
    always @(posedge clk_core) begin
        if (rst_core) begin
            for (int i = 0; i < 64; i++)
                wb_mem[i] <= fill_word(addr_t'(i * 4));
            wb_ack_i <= 1'b0;
            wait_cnt <= 0;
            cyc_q    <= 1'b0;
        end else begin
            cyc_q <= wb_cyc_o;
            if (wb_cyc_o && !cyc_q)
                cyc_starts <= cyc_starts + 1;
            if (wb_ack_i) begin
                wb_ack_i <= 1'b0;
                wait_cnt <= 0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (wait_cnt + 1 >= cur_delay) begin
                    wb_ack_i <= 1'b1;
                    wb_dat_i <= wb_mem[wb_adr_o[7:2]];
                    for (int b = 0; b < 4; b++)
                        if (wb_we_o && wb_sel_o[b])
                            wb_mem[wb_adr_o[7:2]][8*b +: 8] <= wb_dat_o[8*b +: 8];
                    seen_we  <= wb_we_o;
                    seen_sel <= wb_sel_o;
                    seen_adr <= wb_adr_o;
                end else begin
                    wait_cnt <= wait_cnt + 1;
                end
            end
        end
    end

    initial begin
        int data_idx;
        int addr_idx;
        int accept_cycle;
        int cyc_base;
        rst_core <= 1'b1;
        haddr_i  <= '0;
        htrans_i <= htrans_idle;
        hwrite_i <= 1'b0;
        hsize_i  <= 3'd0;
        hwdata_i <= '0;
        void'($urandom(69049));

        // trans, write, addr, size, wdata, ack delay, error
        add_row(htrans_nonseq, 1'b1, 32'h10, 3'd2, 32'hDEAD_BEEF, 1, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h10, 3'd2, 32'h0, 2, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h21, 3'd0, 32'h0000_AB00, 1, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h22, 3'd1, 32'h1234_0000, 1, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h20, 3'd0, 32'h0000_00CD, 3, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h20, 3'd2, 32'h0, 1, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h33, 3'd0, 32'h7700_0000, 1, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h30, 3'd1, 32'h0000_5678, 2, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h30, 3'd2, 32'h0, 1, 1'b0);   // Lane 2 keeps fill
        add_row(htrans_nonseq, 1'b0, 32'h32, 3'd1, 32'h0, 1, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h41, 3'd1, 32'h0, 1, 1'b1);
        add_row(htrans_nonseq, 1'b1, 32'h42, 3'd2, 32'h1111_2222, 1, 1'b1);
        add_row(htrans_nonseq, 1'b0, 32'h43, 3'd2, 32'h0, 1, 1'b1);
        add_row(htrans_nonseq, 1'b0, 32'h48, 3'd3, 32'h0, 1, 1'b1);    // Wider than a word
        add_row(htrans_nonseq, 1'b1, 32'h50, 3'd2, 32'hCAFE_F00D, rand_delay, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h50, 3'd2, 32'h0, rand_delay, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h53, 3'd0, 32'h5A00_0000, rand_delay, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h50, 3'd2, 32'h0, rand_delay, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h10, 3'd2, 32'h0, rand_delay, 1'b0);
        add_row(htrans_idle,   1'b0, 32'h60, 3'd2, 32'h0, 0, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h60, 3'd2, 32'h0102_0304, 1, 1'b0);
        add_row(htrans_nonseq, 1'b1, 32'h64, 3'd2, 32'h0506_0708, 1, 1'b0);
        add_row(htrans_idle,   1'b0, 32'h0,  3'd2, 32'h0, 0, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h60, 3'd2, 32'h0, 1, 1'b0);
        add_row(htrans_seq,    1'b0, 32'h64, 3'd2, 32'h0, 2, 1'b0);
        add_row(htrans_busy,   1'b0, 32'h68, 3'd2, 32'h0, 0, 1'b0);
        add_row(htrans_nonseq, 1'b0, 32'h66, 3'd1, 32'h0, 1, 1'b0);
        cycle_limit += 50;
        for (int i = 0; i < 64; i++)
            shadow[i] = fill_word(addr_t'(i * 4));

        repeat (2) @(posedge clk_core);
        rst_core <= 1'b0;
        @(posedge clk_core);
        check_value("wb_cyc_o", 0, 32'(wb_cyc_o));
        check_value("hready_o", 1, 32'(hready_o));
        check_value("hresp_o", 0, 32'(hresp_o));
        $display("reset: %s", (row_errors == 0) ? "ok" : "mismatch");

        drive_addr(0);
        addr_idx = 0;
        data_idx = -1;
        accept_cycle = 0;
        cyc_base = 0;
        prev_hready = 1'b1;
        prev_hresp = 1'b0;
        while (addr_idx >= 0 || data_idx >= 0) begin
            @(posedge clk_core);
            if (hready_o) begin
                // Data phase ends and the next address phase is taken on this edge
                if (data_idx >= 0)
                    finish_row(data_idx, cycle_cnt - accept_cycle, cyc_starts - cyc_base);
                data_idx = addr_idx;
                accept_cycle = cycle_cnt;
                cyc_base = cyc_starts;
                if (data_idx >= 0) begin
                    hwdata_i  <= rows[data_idx].wdata;
                    cur_delay <= rows[data_idx].delay;
                end
                if (addr_idx >= 0 && addr_idx + 1 < rows.size()) begin
                    addr_idx++;
                    drive_addr(addr_idx);
                end else begin
                    addr_idx = -1;
                    htrans_i <= htrans_idle;
                end
            end
            prev_hready = hready_o;
            prev_hresp = hresp_o;
        end

        errors += DUT.u_assertions.fail_cnt;
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
